// File: verilog/rename_pkg.sv
package rename_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register file sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ARCH_REG_SZ  = 32;
    localparam int PHYS_REG_SZ  = 64;
    localparam int PRN_WIDTH    = 6;
    localparam int ARN_WIDTH    = 5;
    localparam int FL_PTR_WIDTH = 6;
    localparam int FL_CTR_WIDTH = 7;  // Counts 0 to 64 inclusive

    // Only these two opcodes are renamed
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;

    typedef logic [PRN_WIDTH-1:0] prn_t;
    typedef logic [ARN_WIDTH-1:0] arn_t;

    typedef struct packed {
        logic valid;
        prn_t prn;
    } free_list_packet_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction word views
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [6:0] funct7;
        arn_t       rs2;
        arn_t       rs1;
        logic [2:0] funct3;
        arn_t       rd;
        logic [6:0] opcode;
    } r_form_t;

    typedef struct packed {
        logic [11:0] imm12;
        arn_t        rs1;
        logic [2:0]  funct3;
        arn_t        rd;
        logic [6:0]  opcode;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } inst_word_t;

endpackage

// File: verilog/rename_if.sv
`timescale 1ns/10ps

// Decoded group from the decode slot, with stall and flush coming back
interface decoded_if #(
    parameter int LANES = 2
);
    import rename_pkg::*;

    logic [LANES-1:0] valid;
    arn_t [LANES-1:0] dest;
    logic [LANES-1:0] has_dest;
    arn_t [LANES-1:0] src1;
    arn_t [LANES-1:0] src2;
    logic [LANES-1:0] has_src2;
    logic             stall;
    logic             flush;  // Clears the decode slot on a squash copy

    modport source (output valid, dest, has_dest, src1, src2, has_src2, input stall, flush);
    modport sink (input valid, dest, has_dest, src1, src2, has_src2, output stall, flush);
endinterface

// Architectural state and freed registers from the retire side
interface retire_if #(
    parameter int LANES = 2
);
    import rename_pkg::*;

    free_list_packet_t [LANES-1:0]       push;
    logic                                restore;
    prn_t [ARCH_REG_SZ-1:0]              rrat;
    prn_t [PHYS_REG_SZ-1:0]              entries;
    logic [FL_PTR_WIDTH-1:0]             head;
    logic [FL_PTR_WIDTH-1:0]             tail;
    logic [FL_CTR_WIDTH-1:0]             count;

    modport source (output push, restore, rrat, entries, head, tail, count);
    modport sink (input push, restore, rrat, entries, head, tail, count);
endinterface

// File: verilog/free_list.sv
`timescale 1ns/10ps

module free_list #(
    parameter int LANES = 2
) (
    input  logic                                              clock,
    input  logic                                              reset,
    input  rename_pkg::free_list_packet_t [LANES-1:0]         push,
    input  logic [LANES-1:0]                                  pop_en,
    input  logic                                              restore,
    input  rename_pkg::prn_t [rename_pkg::PHYS_REG_SZ-1:0]    restore_entries,
    input  logic [rename_pkg::FL_PTR_WIDTH-1:0]               restore_head,
    input  logic [rename_pkg::FL_PTR_WIDTH-1:0]               restore_tail,
    input  logic [rename_pkg::FL_CTR_WIDTH-1:0]               restore_count,
    output rename_pkg::free_list_packet_t [LANES-1:0]         pop,
    output rename_pkg::prn_t [rename_pkg::PHYS_REG_SZ-1:0]    entries,
    output logic [rename_pkg::FL_PTR_WIDTH-1:0]               head,
    output logic [rename_pkg::FL_PTR_WIDTH-1:0]               tail,
    output logic [rename_pkg::FL_CTR_WIDTH-1:0]               count
);
    import rename_pkg::*;

    prn_t [PHYS_REG_SZ-1:0]  next_entries;
    logic [FL_PTR_WIDTH-1:0] next_head;
    logic [FL_PTR_WIDTH-1:0] next_tail;
    logic [FL_CTR_WIDTH-1:0] next_count;

    always_comb begin
        next_entries = entries;
        next_head    = head;
        next_tail    = tail;
        next_count   = count;

        // Pops come off the head in lane order
        for (int l = 0; l < LANES; l++) begin
            pop[l] = '0;
            if (pop_en[l] && next_count > '0) begin
                pop[l].valid = 1'b1;
                pop[l].prn   = entries[next_head];
                next_head    = next_head + 1'b1;  // Pointers wrap at 64 by width
                next_count   = next_count - 1'b1;
            end
        end

        // Freed registers go in at the tail after the pops
        for (int l = 0; l < LANES; l++) begin
            if (push[l].valid && next_count < PHYS_REG_SZ) begin
                next_entries[next_tail] = push[l].prn;
                next_tail               = next_tail + 1'b1;
                next_count              = next_count + 1'b1;
            end
        end

        if (restore) begin  // The whole state is replaced
            next_entries = restore_entries;
            next_head    = restore_head;
            next_tail    = restore_tail;
            next_count   = restore_count;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (reset) begin
            // Registers 0 to 31 hold the identity mapping, so 32 to 63 are free
            for (int i = 0; i < PHYS_REG_SZ; i++) begin
                entries[i] <= prn_t'(i);
            end
            head  <= FL_PTR_WIDTH'(ARCH_REG_SZ);
            tail  <= '0;
            count <= FL_CTR_WIDTH'(PHYS_REG_SZ - ARCH_REG_SZ);
        end else begin
            entries <= next_entries;
            head    <= next_head;
            tail    <= next_tail;
            count   <= next_count;
        end
    end

endmodule

// File: verilog/rename_decode.sv
`timescale 1ns/10ps

module rename_decode #(
    parameter int LANES = 2
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [LANES-1:0]                      inst_valid,
    input  rename_pkg::inst_word_t [LANES-1:0]    inst,
    output logic                                  inst_ready,
    decoded_if.source                             dec
);
    import rename_pkg::*;

    arn_t [LANES-1:0] dest;
    arn_t [LANES-1:0] src1;
    arn_t [LANES-1:0] src2;
    logic [LANES-1:0] has_src2;

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            dest[l]     = '0;
            src1[l]     = '0;
            src2[l]     = '0;
            has_src2[l] = 1'b0;
            case (inst[l].r_form.opcode)
                OP_REG: begin
                    dest[l]     = inst[l].r_form.rd;
                    src1[l]     = inst[l].r_form.rs1;
                    src2[l]     = inst[l].r_form.rs2;
                    has_src2[l] = 1'b1;
                end
                OP_IMM: begin
                    dest[l] = inst[l].i_form.rd;
                    src1[l] = inst[l].i_form.rs1;
                end
                default: ;  // Not renamed, x0 everywhere
            endcase
        end
    end

    assign inst_ready = !dec.stall;

    always_ff @(posedge clock) begin
        if (reset || dec.flush) begin
            dec.valid <= '0;
        end else if (!dec.stall) begin
            dec.valid <= inst_valid;
        end
    end

    // The slot payload is held while stalled
    always_ff @(posedge clock) begin
        if (!dec.stall) begin
            dec.dest     <= dest;
            dec.src1     <= src1;
            dec.src2     <= src2;
            dec.has_src2 <= has_src2;
            for (int l = 0; l < LANES; l++) begin
                dec.has_dest[l] <= dest[l] != '0;  // x0 never gets a register
            end
        end
    end

endmodule

// File: verilog/rename_map.sv
`timescale 1ns/10ps

module rename_map #(
    parameter int LANES = 2
) (
    input  logic                                 clock,
    input  logic                                 reset,
    decoded_if.sink                              dec,
    retire_if.sink                               ret,
    output logic [LANES-1:0]                     out_valid,
    output rename_pkg::prn_t [LANES-1:0]         out_src1,
    output rename_pkg::prn_t [LANES-1:0]         out_src2,
    output rename_pkg::prn_t [LANES-1:0]         out_dest,
    output rename_pkg::prn_t [LANES-1:0]         out_old_dest,
    output logic [rename_pkg::FL_CTR_WIDTH-1:0]  free_count
);
    import rename_pkg::*;

    prn_t [ARCH_REG_SZ-1:0]  rat;
    prn_t [ARCH_REG_SZ-1:0]  rat_next;
    free_list_packet_t [LANES-1:0] pop;
    logic [LANES-1:0]        pop_en;
    logic [FL_CTR_WIDTH-1:0] need;
    logic                    accept;
    prn_t [LANES-1:0]        src1;
    prn_t [LANES-1:0]        src2;
    prn_t [LANES-1:0]        dest;
    prn_t [LANES-1:0]        old_dest;

    // The group waits whole until there are enough free registers
    always_comb begin
        need = '0;
        for (int l = 0; l < LANES; l++) begin
            if (dec.valid[l] && dec.has_dest[l]) need = need + 1'b1;
        end
    end

    assign dec.stall = need > free_count;
    assign dec.flush = ret.restore;
    assign accept    = !dec.stall && !ret.restore;
    assign pop_en    = accept ? (dec.valid & dec.has_dest) : '0;

    free_list #(.LANES(LANES)) spec_list (
        .clock(clock), .reset(reset),
        .push(ret.push), .pop_en(pop_en),
        .restore(ret.restore), .restore_entries(ret.entries),
        .restore_head(ret.head), .restore_tail(ret.tail), .restore_count(ret.count),
        .pop(pop), .entries(), .head(), .tail(), .count(free_count)
    );

    // Reading the partly updated copy forwards earlier lanes' destinations
    always_comb begin
        rat_next = rat;
        for (int l = 0; l < LANES; l++) begin
            src1[l]     = rat_next[dec.src1[l]];
            src2[l]     = dec.has_src2[l] ? rat_next[dec.src2[l]] : '0;
            dest[l]     = '0;
            old_dest[l] = '0;
            if (pop_en[l]) begin
                old_dest[l]           = rat_next[dec.dest[l]];
                dest[l]               = pop[l].prn;
                rat_next[dec.dest[l]] = pop[l].prn;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REG_SZ; i++) rat[i] <= prn_t'(i);
            out_valid <= '0;
        end else if (ret.restore) begin
            rat       <= ret.rrat;  // Back to the retired mappings
            out_valid <= '0;
        end else begin
            rat       <= rat_next;
            out_valid <= accept ? dec.valid : '0;
        end
    end

    always_ff @(posedge clock) begin
        out_src1     <= src1;
        out_src2     <= src2;
        out_dest     <= dest;
        out_old_dest <= old_dest;
    end

endmodule

// File: verilog/retire_map.sv
`timescale 1ns/10ps

module retire_map #(
    parameter int LANES = 2
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [LANES-1:0]                retire_valid,
    input  rename_pkg::arn_t [LANES-1:0]    retire_arch,
    input  logic                            squash,
    retire_if.source                        ret
);
    import rename_pkg::*;

    prn_t [ARCH_REG_SZ-1:0]        rrat;
    prn_t [ARCH_REG_SZ-1:0]        rrat_next;
    logic [LANES-1:0]              pop_en;
    free_list_packet_t [LANES-1:0] pop;
    free_list_packet_t [LANES-1:0] push;

    // A retiring x0 has nothing to commit
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            pop_en[l] = retire_valid[l] && retire_arch[l] != '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Commit in program order
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rrat_next = rrat;
        for (int l = 0; l < LANES; l++) begin
            push[l] = '0;
            if (pop[l].valid) begin
                push[l].valid             = 1'b1;
                push[l].prn               = rrat_next[retire_arch[l]];
                rrat_next[retire_arch[l]] = pop[l].prn;
            end
        end
    end

    free_list #(.LANES(LANES)) arch_list (
        .clock(clock), .reset(reset),
        .push(push), .pop_en(pop_en),
        .restore(1'b0), .restore_entries('0),
        .restore_head('0), .restore_tail('0), .restore_count('0),
        .pop(pop), .entries(ret.entries),
        .head(ret.head), .tail(ret.tail), .count(ret.count)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REG_SZ; i++) rrat[i] <= prn_t'(i);
        end else begin
            rrat <= rrat_next;
        end
    end

    // The copy is of the state before this cycle's retirements
    assign ret.restore = squash;
    assign ret.push    = push;  // Old mappings go back to both lists
    assign ret.rrat    = rrat;

endmodule

// File: verilog/rename_top.sv
`timescale 1ns/10ps

module rename_top #(
    parameter int LANES = 2
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [LANES-1:0]                     inst_valid,
    input  rename_pkg::inst_word_t [LANES-1:0]   inst,
    input  logic [LANES-1:0]                     retire_valid,
    input  rename_pkg::arn_t [LANES-1:0]         retire_arch,
    input  logic                                 squash,
    output logic                                 inst_ready,
    output logic [LANES-1:0]                     out_valid,
    output rename_pkg::prn_t [LANES-1:0]         out_src1,
    output rename_pkg::prn_t [LANES-1:0]         out_src2,
    output rename_pkg::prn_t [LANES-1:0]         out_dest,
    output rename_pkg::prn_t [LANES-1:0]         out_old_dest,
    output logic [rename_pkg::FL_CTR_WIDTH-1:0]  free_count
);

    decoded_if #(.LANES(LANES)) dec_bus ();
    retire_if  #(.LANES(LANES)) ret_bus ();

    // Decode slot, first pipeline edge
    rename_decode #(.LANES(LANES)) rename_decode_inst (
        .clock(clock), .reset(reset),
        .inst_valid(inst_valid), .inst(inst),
        .inst_ready(inst_ready),
        .dec(dec_bus.source)
    );

    // Map and speculative free list, second edge
    rename_map #(.LANES(LANES)) rename_map_inst (
        .clock(clock), .reset(reset),
        .dec(dec_bus.sink), .ret(ret_bus.sink),
        .out_valid(out_valid),
        .out_src1(out_src1), .out_src2(out_src2),
        .out_dest(out_dest), .out_old_dest(out_old_dest),
        .free_count(free_count)
    );

    retire_map #(.LANES(LANES)) retire_map_inst (
        .clock(clock), .reset(reset),
        .retire_valid(retire_valid), .retire_arch(retire_arch),
        .squash(squash),
        .ret(ret_bus.source)
    );

endmodule

// File: verification/rename_tb.sv
`timescale 1ns/10ps

module rename_tb;
    import rename_pkg::*;

    localparam int LANES      = 2;
    localparam int WAIT_LIMIT = 50;

    typedef struct {
        int          tid;
        logic [1:0]  iv;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [1:0]  rv;
        arn_t        ra0;
        arn_t        ra1;
        logic        sq;
        logic        st;
        int          rep;
    } row_t;

    // One lane of the model, used for the decode slot and for the outputs
    typedef struct {
        int v;
        int d;
        int hd;
        int s1;
        int s2;
        int h2;
        int od;
    } lane_t;

    logic                    clock;
    logic                    reset;
    logic [LANES-1:0]        inst_valid;
    inst_word_t [LANES-1:0]  inst;
    logic [LANES-1:0]        retire_valid;
    arn_t [LANES-1:0]        retire_arch;
    logic                    squash;
    logic                    inst_ready;
    logic [LANES-1:0]        out_valid;
    prn_t [LANES-1:0]        out_src1;
    prn_t [LANES-1:0]        out_src2;
    prn_t [LANES-1:0]        out_dest;
    prn_t [LANES-1:0]        out_old_dest;
    logic [FL_CTR_WIDTH-1:0] free_count;

    int          m_rat[ARCH_REG_SZ];
    int          m_rrat[ARCH_REG_SZ];
    int          m_spec[$];
    int          m_arch[$];
    lane_t       slot[LANES];
    lane_t       outs[LANES];
    row_t        rows[$];
    logic [31:0] lfsr;
    int          checks;
    int          errors;
    bit          timed_out;
    string       test_name[5] = '{"after reset", "in-group dependency", "immediate form",
                                  "exhaustion", "squash"};

    rename_top #(.LANES(LANES)) rename_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
    endfunction

    function automatic arn_t rand_arn();
        arn_t a;
        for (int i = 0; i < 5; i++) begin
            lfsr = lfsr_next(lfsr);
            a[i] = lfsr[0];
        end
        return a;
    endfunction

    function automatic arn_t rand_rd();
        arn_t a;
        a = rand_arn();
        return (a == '0) ? 5'd1 : a;
    endfunction

    function automatic logic [31:0] r_word(arn_t rd, arn_t rs1, arn_t rs2);
        return {7'b0, rs2, rs1, 3'b0, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_word(arn_t rd, arn_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b0, rd, OP_IMM};
    endfunction

    task automatic add(int tid, logic [1:0] iv, logic [31:0] w0, logic [31:0] w1,
                       logic [1:0] rv, arn_t ra0, arn_t ra1, logic sq, logic st, int rep);
        rows.push_back('{tid, iv, w0, w1, rv, ra0, ra1, sq, st, rep});
    endtask

    // Field split of a word as the decode stage sees it
    function automatic lane_t decode_word(logic v, logic [31:0] w);
        lane_t x;
        x   = '{default: 0};
        x.v = v;
        if (w[6:0] == OP_REG || w[6:0] == OP_IMM) begin
            x.d  = w[11:7];
            x.hd = (w[11:7] != 0);
            x.s1 = w[19:15];
            x.h2 = (w[6:0] == OP_REG);
            x.s2 = x.h2 ? w[24:20] : 0;
        end
        return x;
    endfunction

    function automatic bit pipeline_busy();
        return slot[0].v != 0 || slot[1].v != 0 || outs[0].v != 0 || outs[1].v != 0;
    endfunction

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic report_timeout(string what);
        errors++;
        timed_out = 1'b1;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    task automatic check_outputs();
        for (int l = 0; l < LANES; l++) begin
            check_val($sformatf("out_valid[%0d]", l), outs[l].v, out_valid[l]);
            if (outs[l].v != 0) begin
                check_val($sformatf("out_src1[%0d]", l), outs[l].s1, out_src1[l]);
                check_val($sformatf("out_src2[%0d]", l), outs[l].s2, out_src2[l]);
                check_val($sformatf("out_dest[%0d]", l), outs[l].d, out_dest[l]);
                check_val($sformatf("out_old_dest[%0d]", l), outs[l].od, out_old_dest[l]);
            end
        end
        check_val("free_count", m_spec.size(), free_count);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One clock of the reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic cycle();
        int   need;
        logic stall;
        int   nw;
        int   freed[$];
        int   rrat_snap[ARCH_REG_SZ];
        int   arch_snap[$];

        check_outputs();
        need = 0;
        for (int l = 0; l < LANES; l++) need += (slot[l].v != 0 && slot[l].hd != 0) ? 1 : 0;
        stall = need > m_spec.size();  // The group waits whole
        check_val("inst_ready", !stall, inst_ready);
        rrat_snap = m_rrat;
        arch_snap = m_arch;
        for (int l = 0; l < LANES; l++) begin
            if (retire_valid[l] && retire_arch[l] != '0) begin
                nw = m_arch.pop_front();
                freed.push_back(m_rrat[retire_arch[l]]);
                m_rrat[retire_arch[l]] = nw;
            end
        end
        foreach (freed[i]) m_arch.push_back(freed[i]);
        for (int l = 0; l < LANES; l++) outs[l].v = 0;
        if (squash) begin
            m_rat  = rrat_snap;
            m_spec = arch_snap;
            for (int l = 0; l < LANES; l++) slot[l].v = 0;
        end else begin
            for (int l = 0; l < LANES; l++) begin
                if (!stall && slot[l].v != 0) begin
                    outs[l] = '{v: 1, default: 0};
                    outs[l].s1 = m_rat[slot[l].s1];  // Earlier lanes already updated m_rat
                    outs[l].s2 = (slot[l].h2 != 0) ? m_rat[slot[l].s2] : 0;
                    if (slot[l].hd != 0) begin
                        outs[l].od       = m_rat[slot[l].d];
                        outs[l].d        = m_spec.pop_front();
                        m_rat[slot[l].d] = outs[l].d;
                    end
                end
                if (!stall) slot[l] = decode_word(inst_valid[l], inst[l]);
            end
            foreach (freed[i]) m_spec.push_back(freed[i]);
        end
        @(posedge clock);
        #2;
    endtask

    task automatic drain();
        int t;
        t            = 0;
        inst_valid   = '0;
        retire_valid = '0;
        squash       = 1'b0;
        while (pipeline_busy() && t < WAIT_LIMIT) begin
            cycle();
            t++;
        end
        if (pipeline_busy()) begin
            report_timeout("pipeline did not drain");
        end else begin
            check_outputs();
        end
    endtask

    initial begin
        int   t;
        int   first_err;
        row_t r;

        reset        = 1'b1;
        inst_valid   = '0;
        inst         = '0;
        retire_valid = '0;
        retire_arch  = '0;
        squash       = 1'b0;
        lfsr         = 32'h4fe8_ce84;
        checks       = 0;
        errors       = 0;
        timed_out    = 1'b0;
        first_err    = 0;
        for (int i = 0; i < ARCH_REG_SZ; i++) begin
            m_rat[i]  = i;
            m_rrat[i] = i;
        end
        for (int i = ARCH_REG_SZ; i < PHYS_REG_SZ; i++) begin
            m_spec.push_back(i);
            m_arch.push_back(i);
        end
        for (int l = 0; l < LANES; l++) begin
            slot[l] = '{default: 0};
            outs[l] = '{default: 0};
        end

        add(0, 2'b11, r_word(1, 5, 6), r_word(2, 7, 8), 0, 0, 0, 0, 0, 1);
        add(1, 2'b11, r_word(3, 1, 2), r_word(4, 3, 3), 0, 0, 0, 0, 0, 1);
        add(2, 2'b11, i_word(0, 4, 12'h7ff), i_word(5, 0, 12'h001), 0, 0, 0, 0, 0, 1);
        add(3, 2'b11, 0, 0, 0, 0, 0, 0, 0, 13);  // Repeated rows take LFSR fields
        add(3, 2'b11, r_word(9, 9, 10), r_word(10, 9, 0), 0, 0, 0, 0, 0, 1);
        add(3, 2'b00, 0, 0, 0, 0, 0, 0, 1, 1);
        add(3, 2'b00, 0, 0, 2'b11, 1, 2, 0, 1, 1);
        add(4, 2'b00, 0, 0, 2'b11, 3, 4, 0, 0, 1);
        add(4, 2'b00, 0, 0, 2'b11, 5, 6, 0, 0, 1);
        add(4, 2'b11, r_word(10, 1, 2), r_word(11, 10, 3), 0, 0, 0, 0, 0, 1);
        add(4, 2'b11, i_word(12, 10, 12'h005), r_word(13, 11, 12), 0, 0, 0, 0, 0, 1);
        add(4, 2'b00, 0, 0, 0, 0, 0, 1, 0, 1);
        add(4, 2'b11, r_word(14, 10, 11), r_word(15, 1, 12), 0, 0, 0, 0, 0, 1);

        repeat (16) @(posedge clock);
        #2;
        reset = 1'b0;

        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            r = rows[i];
            for (int k = 0; k < r.rep && !timed_out; k++) begin
                if (r.rep > 1) begin
                    r.w0 = r_word(rand_rd(), rand_arn(), rand_arn());
                    r.w1 = r_word(rand_rd(), rand_arn(), rand_arn());
                end
                inst_valid     = r.iv;
                inst[0]        = r.w0;
                inst[1]        = r.w1;
                retire_valid   = r.rv;
                retire_arch[0] = r.ra0;
                retire_arch[1] = r.ra1;
                squash         = r.sq;
                check_val("inst_ready", !r.st, inst_ready);
                t = 0;
                while (r.iv != '0 && !inst_ready && t < WAIT_LIMIT) begin
                    cycle();
                    t++;
                end
                if (r.iv != '0 && !inst_ready) begin
                    report_timeout("inst_ready stayed low");
                end else begin
                    cycle();
                end
            end
            if (!timed_out && (i == rows.size() - 1 || rows[i+1].tid != r.tid)) begin
                drain();
                $display("test %0d %s: %0d errors", r.tid + 1, test_name[r.tid],
                         errors - first_err);
                first_err = errors;
            end
        end

        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: rename_unit.f
verilog/rename_pkg.sv
verilog/rename_if.sv
verilog/free_list.sv
verilog/rename_decode.sv
verilog/rename_map.sv
verilog/retire_map.sv
verilog/rename_top.sv
verification/rename_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only on the pass line
verilator --binary --timing -Wno-fatal --top-module rename_tb \
    -f rename_unit.f -o rename_sim &&
./obj_dir/rename_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" ||
{ echo "rename_unit simulation did not pass"; exit 1; }
